// File: hw/axi4_mon_pkg.sv
// Shared widths and types of the AXI4 protocol monitor
// Every width below matches one AXI4 link with a 32-bit address and 64-bit data
package axi4_mon_pkg;

	// Address bus width
	localparam int ADDR_W = 32;

	// Data bus width of the W and R channels
	localparam int DATA_W = 64;

	// One strobe bit per byte lane
	localparam int STRB_W = DATA_W / 8;

	// Burst length field (AxLEN), beats minus one
	localparam int LEN_W = 8;

	// Beat size field (AxSIZE), log2 of bytes per beat
	localparam int SIZE_W = 3;

	// Burst type field (AxBURST): FIXED, INCR or WRAP
	localparam int BURST_W = 2;

	// Response code width on B and R
	localparam int RESP_W = 2;

	// Outstanding-write counters are 4 bits wide and saturate at 15
	localparam int OUTST_W = 4;
	localparam logic [OUTST_W-1:0] OUTST_MAX = '1;

	// The violation count is 8 bits wide and saturates at 255
	localparam int VIOL_CNT_W = 8;
	localparam logic [VIOL_CNT_W-1:0] VIOL_CNT_MAX = '1;

	// Write address channel payload, 45 bits
	typedef struct packed {
		logic [ADDR_W-1:0]  addr;
		logic [LEN_W-1:0]   len;
		logic [SIZE_W-1:0]  size;
		logic [BURST_W-1:0] burst;
	} aw_ch_t;

	// Read address channel payload, same layout as AW
	typedef struct packed {
		logic [ADDR_W-1:0]  addr;
		logic [LEN_W-1:0]   len;
		logic [SIZE_W-1:0]  size;
		logic [BURST_W-1:0] burst;
	} ar_ch_t;

	// Write data channel payload, 73 bits
	// The last bit also feeds the write-response ordering check
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
		logic              last;
	} w_ch_t;

	// Write response channel payload
	typedef struct packed {
		logic [RESP_W-1:0] resp;
	} b_ch_t;

	// Read data channel payload, 67 bits
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [RESP_W-1:0] resp;
		logic              last;
	} r_ch_t;

	// One flag per rule, all raised in the same cycle when the rules break together
	// The five stability flags come first, then the two B ordering flags
	typedef struct packed {
		logic aw_unstable;
		logic w_unstable;
		logic b_unstable;
		logic ar_unstable;
		logic r_unstable;
		// BVALID seen while no accepted AW waits for its response
		logic b_without_aw;
		// BVALID seen while no complete W burst waits for its response
		logic b_without_wlast;
	} viol_t;

endpackage

// File: hw/axi4_chan_stable.sv
`timescale 1ns/1ps

// Stability checker for one valid/ready channel
// Once valid is high and ready is low, valid has to stay high and the
// payload has to hold its value until the handshake takes place
module axi4_chan_stable #(
	parameter int PAYLOAD_W = 8
) (
	input  logic                 aclk,
	input  logic                 arst_n,
	input  logic                 valid,
	input  logic                 ready,
	input  logic [PAYLOAD_W-1:0] payload,
	output logic                 unstable
);

	// High while the previous edge saw a stalled beat
	logic armed;

	// Copy of the payload taken at the stalled edge
	logic [PAYLOAD_W-1:0] held;

	// Valid without ready at this edge, so the beat must be held
	logic stall;

	// Rule broken at this edge against the beat stored before it
	logic broken;

	assign stall = valid && !ready;

	// A stalled beat may only end in a handshake with the same payload
	// Dropping valid or changing any payload bit both count as a break
	assign broken = armed && (!valid || (payload != held));

	// Armed follows the stall of each edge, so a handshake or a low valid
	// disarms the checker and a longer stall simply keeps it armed
	always_ff @(posedge aclk or negedge arst_n) begin
		if (!arst_n) begin
			armed    <= 1'b0;
			unstable <= 1'b0;
		end else begin
			armed    <= stall;
			unstable <= broken;
		end
	end

	// The copy is refreshed on every stalled edge
	// After a payload change the new value becomes the reference, which
	// keeps a single change down to a single flagged cycle
	always_ff @(posedge aclk) begin
		if (stall) begin
			held <= payload;
		end
	end

	// A flag needs a stalled beat on the port two edges back
	// One edge arms the checker and the next one compares
	a_flag_needs_arm: assert property (
		@(posedge aclk) disable iff (!arst_n)
		unstable |-> $past(valid && !ready, 2)
	) else $error("unstable raised without a pending stalled beat");

endmodule

// File: hw/axi4_wresp_order.sv
`timescale 1ns/1ps

// Write-response ordering checker
// A write response is only legal once both its address and the last beat of
// its data burst have been accepted, so BVALID needs one open AW and one
// open W burst behind it
module axi4_wresp_order (
	input  logic aclk,
	input  logic arst_n,
	input  logic awvalid,
	input  logic awready,
	input  logic wvalid,
	input  logic wready,
	input  logic wlast,
	input  logic bvalid,
	input  logic bready,
	output logic b_without_aw,
	output logic b_without_wlast
);

	// Handshakes seen at this edge
	logic aw_hs;
	logic wlast_hs;
	logic b_hs;

	// Accepted AW and complete W bursts that still wait for a response
	logic [axi4_mon_pkg::OUTST_W-1:0] aw_open;
	logic [axi4_mon_pkg::OUTST_W-1:0] w_open;

	assign aw_hs    = awvalid && awready;
	assign wlast_hs = wvalid && wready && wlast;
	assign b_hs     = bvalid && bready;

	// Next value of one outstanding counter
	// An opening and a closing handshake in the same cycle cancel out
	// The count sticks at its maximum and never drops below zero
	function automatic logic [axi4_mon_pkg::OUTST_W-1:0] step(
		input logic [axi4_mon_pkg::OUTST_W-1:0] cnt,
		input logic                             up,
		input logic                             down
	);
		logic [axi4_mon_pkg::OUTST_W-1:0] nxt;
		nxt = cnt;
		if (up && !down && (cnt != axi4_mon_pkg::OUTST_MAX)) begin
			nxt = cnt + 1'b1;
		end else if (down && !up && (cnt != '0)) begin
			nxt = cnt - 1'b1;
		end
		return nxt;
	endfunction

	always_ff @(posedge aclk or negedge arst_n) begin
		if (!arst_n) begin
			aw_open         <= '0;
			w_open          <= '0;
			b_without_aw    <= 1'b0;
			b_without_wlast <= 1'b0;
		end else begin
			aw_open <= step(aw_open, aw_hs, b_hs);
			w_open  <= step(w_open, wlast_hs, b_hs);
			// Every BVALID cycle is judged on the counts before this edge,
			// so a stalled orphan response is flagged once per cycle
			b_without_aw    <= bvalid && (aw_open == '0);
			b_without_wlast <= bvalid && (w_open == '0);
		end
	end

	// A full counter can only stay full or step down by one, never roll over to zero
	a_aw_no_wrap: assert property (
		@(posedge aclk) disable iff (!arst_n)
		(aw_open == axi4_mon_pkg::OUTST_MAX) |=> (aw_open != '0)
	) else $error("outstanding AW counter wrapped past its maximum");

	a_w_no_wrap: assert property (
		@(posedge aclk) disable iff (!arst_n)
		(w_open == axi4_mon_pkg::OUTST_MAX) |=> (w_open != '0)
	) else $error("outstanding W burst counter wrapped past its maximum");

endmodule

// File: hw/axi4_viol_log.sv
`timescale 1ns/1ps

// Violation log
// Turns the per-cycle violation record into a pulse, a sticky status word,
// the first record seen and a saturating count of violating cycles
module axi4_viol_log (
	input  logic                                aclk,
	input  logic                                arst_n,
	input  logic                                clr,
	input  axi4_mon_pkg::viol_t                 viol,
	output logic                                viol_pulse,
	output axi4_mon_pkg::viol_t                 viol_status,
	output axi4_mon_pkg::viol_t                 first_viol,
	output logic [axi4_mon_pkg::VIOL_CNT_W-1:0] viol_count
);

	// Any rule broken in this cycle
	logic any_viol;

	// Nothing has been captured yet since reset or the last clr
	logic first_free;

	assign any_viol   = |viol;
	assign first_free = (first_viol == '0);

	always_ff @(posedge aclk or negedge arst_n) begin
		if (!arst_n) begin
			viol_pulse  <= 1'b0;
			viol_status <= '0;
			first_viol  <= '0;
			viol_count  <= '0;
		end else begin
			// The pulse just follows the record one cycle later
			viol_pulse <= any_viol;
			// clr wins over a violation arriving at the same edge
			if (clr) begin
				viol_status <= '0;
				first_viol  <= '0;
				viol_count  <= '0;
			end else begin
				viol_status <= viol_status | viol;
				// A captured record is never empty, so an all-zero word
				// marks the slot as free
				if (any_viol && first_free) begin
					first_viol <= viol;
				end
				if (any_viol && (viol_count != axi4_mon_pkg::VIOL_CNT_MAX)) begin
					viol_count <= viol_count + 1'b1;
				end
			end
		end
	end

	// Only clr brings the count down
	a_count_monotonic: assert property (
		@(posedge aclk) disable iff (!arst_n)
		!clr |=> (viol_count >= $past(viol_count))
	) else $error("viol_count decreased without clr");

	// Every flag that pulsed is kept in the sticky status
	a_status_holds_pulse: assert property (
		@(posedge aclk) disable iff (!arst_n)
		(any_viol && !clr) |=> ((viol_status & $past(viol)) == $past(viol))
	) else $error("viol_status lost a flag that was just reported");

endmodule

// File: hw/axi4_mon_top.sv
`timescale 1ns/1ps

// Passive AXI4 protocol monitor
// Watches all five channels of one link and reports broken rules as status
// It drives nothing back onto the link
module axi4_mon_top (
	input  logic                                aclk,
	input  logic                                arst_n,
	input  logic                                clr,
	// Write address channel
	input  axi4_mon_pkg::aw_ch_t                aw,
	input  logic                                awvalid,
	input  logic                                awready,
	// Write data channel
	input  axi4_mon_pkg::w_ch_t                 w,
	input  logic                                wvalid,
	input  logic                                wready,
	// Write response channel
	input  axi4_mon_pkg::b_ch_t                 b,
	input  logic                                bvalid,
	input  logic                                bready,
	// Read address channel
	input  axi4_mon_pkg::ar_ch_t                ar,
	input  logic                                arvalid,
	input  logic                                arready,
	// Read data channel
	input  axi4_mon_pkg::r_ch_t                 r,
	input  logic                                rvalid,
	input  logic                                rready,
	// Results, two cycles after the offending edge
	output logic                                viol_pulse,
	output axi4_mon_pkg::viol_t                 viol_status,
	output axi4_mon_pkg::viol_t                 first_viol,
	output logic [axi4_mon_pkg::VIOL_CNT_W-1:0] viol_count
);

	// All seven rule flags of one cycle
	axi4_mon_pkg::viol_t viol;

	// One stability checker per channel, each as wide as its payload
	axi4_chan_stable #(
		.PAYLOAD_W($bits(axi4_mon_pkg::aw_ch_t))
	) u_aw_stable (
		.aclk     (aclk),
		.arst_n   (arst_n),
		.valid    (awvalid),
		.ready    (awready),
		.payload  (aw),
		.unstable (viol.aw_unstable)
	);

	axi4_chan_stable #(
		.PAYLOAD_W($bits(axi4_mon_pkg::w_ch_t))
	) u_w_stable (
		.aclk     (aclk),
		.arst_n   (arst_n),
		.valid    (wvalid),
		.ready    (wready),
		.payload  (w),
		.unstable (viol.w_unstable)
	);

	axi4_chan_stable #(
		.PAYLOAD_W($bits(axi4_mon_pkg::b_ch_t))
	) u_b_stable (
		.aclk     (aclk),
		.arst_n   (arst_n),
		.valid    (bvalid),
		.ready    (bready),
		.payload  (b),
		.unstable (viol.b_unstable)
	);

	axi4_chan_stable #(
		.PAYLOAD_W($bits(axi4_mon_pkg::ar_ch_t))
	) u_ar_stable (
		.aclk     (aclk),
		.arst_n   (arst_n),
		.valid    (arvalid),
		.ready    (arready),
		.payload  (ar),
		.unstable (viol.ar_unstable)
	);

	axi4_chan_stable #(
		.PAYLOAD_W($bits(axi4_mon_pkg::r_ch_t))
	) u_r_stable (
		.aclk     (aclk),
		.arst_n   (arst_n),
		.valid    (rvalid),
		.ready    (rready),
		.payload  (r),
		.unstable (viol.r_unstable)
	);

	// B may only follow an accepted AW and a complete W burst
	axi4_wresp_order u_wresp_order (
		.aclk            (aclk),
		.arst_n          (arst_n),
		.awvalid         (awvalid),
		.awready         (awready),
		.wvalid          (wvalid),
		.wready          (wready),
		.wlast           (w.last),
		.bvalid          (bvalid),
		.bready          (bready),
		.b_without_aw    (viol.b_without_aw),
		.b_without_wlast (viol.b_without_wlast)
	);

	axi4_viol_log u_viol_log (
		.aclk        (aclk),
		.arst_n      (arst_n),
		.clr         (clr),
		.viol        (viol),
		.viol_pulse  (viol_pulse),
		.viol_status (viol_status),
		.first_viol  (first_viol),
		.viol_count  (viol_count)
	);

endmodule

// File: include/axi4_mon_vectors.svh
`ifndef AXI4_MON_VECTORS_SVH
`define AXI4_MON_VECTORS_SVH

// Channel that a scenario drives
typedef enum logic [2:0] {VEC_CH_AW, VEC_CH_W, VEC_CH_B, VEC_CH_AR, VEC_CH_R} vec_chan_e;

// Scenario kinds
// A B-channel beat is always preceded by one accepted AW and W burst unless
// the kind itself is about a missing one
// An early valid drop lasts one cycle, then the beat is presented again and accepted
// VEC_B_NO_AW is one bvalid cycle with neither an AW nor a W burst before it
// VEC_B_NO_WLAST is one bvalid cycle after an AW but without any W burst
typedef enum logic [2:0] {
	VEC_LEGAL_STALL,
	VEC_PAYLOAD_CHANGE,
	VEC_VALID_DROP,
	VEC_B_NO_AW,
	VEC_B_NO_WLAST,
	VEC_LEGAL_WRITE,
	VEC_TWO_WRITES
} vec_kind_e;

// One scenario row
// The stall is counted in cycles with valid high and ready low
typedef struct packed {
	logic [8*16-1:0]     name;
	vec_chan_e           chan;
	vec_kind_e           kind;
	logic [3:0]          stall;
	axi4_mon_pkg::viol_t exp_status;
	logic [7:0]          exp_incr;
} vec_t;

localparam int NUM_VECS = 19;

localparam vec_t VECS [NUM_VECS] = '{
	'{"legal_aw", VEC_CH_AW, VEC_LEGAL_STALL, 4'd3, '0, 8'd0},
	'{"legal_w", VEC_CH_W, VEC_LEGAL_STALL, 4'd0, '0, 8'd0},
	'{"legal_b", VEC_CH_B, VEC_LEGAL_STALL, 4'd5, '0, 8'd0},
	'{"legal_ar", VEC_CH_AR, VEC_LEGAL_STALL, 4'd2, '0, 8'd0},
	'{"legal_r", VEC_CH_R, VEC_LEGAL_STALL, 4'd4, '0, 8'd0},
	'{"chg_aw", VEC_CH_AW, VEC_PAYLOAD_CHANGE, 4'd3, '{aw_unstable: 1'b1, default: 1'b0}, 8'd1},
	'{"chg_w", VEC_CH_W, VEC_PAYLOAD_CHANGE, 4'd2, '{w_unstable: 1'b1, default: 1'b0}, 8'd1},
	'{"chg_b", VEC_CH_B, VEC_PAYLOAD_CHANGE, 4'd2, '{b_unstable: 1'b1, default: 1'b0}, 8'd1},
	'{"chg_ar", VEC_CH_AR, VEC_PAYLOAD_CHANGE, 4'd4, '{ar_unstable: 1'b1, default: 1'b0}, 8'd1},
	'{"chg_r", VEC_CH_R, VEC_PAYLOAD_CHANGE, 4'd3, '{r_unstable: 1'b1, default: 1'b0}, 8'd1},
	'{"drop_aw", VEC_CH_AW, VEC_VALID_DROP, 4'd2, '{aw_unstable: 1'b1, default: 1'b0}, 8'd1},
	'{"drop_w", VEC_CH_W, VEC_VALID_DROP, 4'd3, '{w_unstable: 1'b1, default: 1'b0}, 8'd1},
	'{"drop_b", VEC_CH_B, VEC_VALID_DROP, 4'd2, '{b_unstable: 1'b1, default: 1'b0}, 8'd1},
	'{"drop_ar", VEC_CH_AR, VEC_VALID_DROP, 4'd1, '{ar_unstable: 1'b1, default: 1'b0}, 8'd1},
	'{"drop_r", VEC_CH_R, VEC_VALID_DROP, 4'd2, '{r_unstable: 1'b1, default: 1'b0}, 8'd1},
	'{"b_orphan", VEC_CH_B, VEC_B_NO_AW, 4'd0,
		'{b_without_aw: 1'b1, b_without_wlast: 1'b1, default: 1'b0}, 8'd1},
	'{"b_no_wlast", VEC_CH_B, VEC_B_NO_WLAST, 4'd0, '{b_without_wlast: 1'b1, default: 1'b0}, 8'd1},
	'{"legal_write", VEC_CH_B, VEC_LEGAL_WRITE, 4'd2, '0, 8'd0},
	'{"two_writes", VEC_CH_B, VEC_TWO_WRITES, 4'd1, '0, 8'd0}
};

`endif

// File: verif/axi4_mon_tb.sv
`timescale 1ns/1ps

// Testbench of the AXI4 protocol monitor
// Plays each scenario of the vector table on the link and then checks the
// monitor's status, first record, count and number of pulses
module axi4_mon_tb;

	`include "axi4_mon_vectors.svh"

	logic aclk;
	logic arst_n;
	logic clr;
	// Valid and ready of all five channels, indexed by vec_chan_e
	logic [4:0] vld;
	logic [4:0] rdy;
	axi4_mon_pkg::aw_ch_t aw;
	axi4_mon_pkg::w_ch_t  w;
	axi4_mon_pkg::b_ch_t  b;
	axi4_mon_pkg::ar_ch_t ar;
	axi4_mon_pkg::r_ch_t  r;
	logic viol_pulse;
	axi4_mon_pkg::viol_t viol_status;
	axi4_mon_pkg::viol_t first_viol;
	logic [axi4_mon_pkg::VIOL_CNT_W-1:0] viol_count;

	integer seed = 32'h265d;
	int errors = 0;
	int checks = 0;
	// Number of cycles with viol_pulse high since time zero
	int pulses = 0;
	// Writes opened on the link and still waiting for B, counted by the AXI rules
	int aw_open = 0;
	int w_open = 0;

	always #4 aclk = ~aclk;

	// Sampled at the edge, so the count lags the pulse by one cycle
	always @(posedge aclk) begin
		if (viol_pulse) begin
			pulses <= pulses + 1;
		end
	end

	axi4_mon_top dut0 (
		.*,
		.awvalid (vld[VEC_CH_AW]),
		.awready (rdy[VEC_CH_AW]),
		.wvalid  (vld[VEC_CH_W]),
		.wready  (rdy[VEC_CH_W]),
		.bvalid  (vld[VEC_CH_B]),
		.bready  (rdy[VEC_CH_B]),
		.arvalid (vld[VEC_CH_AR]),
		.arready (rdy[VEC_CH_AR]),
		.rvalid  (vld[VEC_CH_R]),
		.rready  (rdy[VEC_CH_R])
	);

	task automatic compare(input string test, input string field,
			input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("Mismatch %0s %0s expected 0x%0h actual 0x%0h", test, field, exp, act);
		end
	endtask

	// Wide enough for the largest payload, W at 73 bits
	function automatic logic [72:0] rand_payload();
		logic [95:0] raw;
		raw = {$random(seed), $random(seed), $random(seed)};
		return raw[72:0];
	endfunction

	// One sampled edge of one channel, all other channels idle
	task automatic beat(input vec_chan_e chan, input logic v, input logic rd,
			input logic [72:0] p);
		@(posedge aclk);
		vld <= '0;
		rdy <= '0;
		vld[chan] <= v;
		rdy[chan] <= rd;
		case (chan)
			VEC_CH_AW: aw <= p[$bits(aw)-1:0];
			VEC_CH_W:  w <= p[$bits(w)-1:0];
			VEC_CH_B:  b <= p[$bits(b)-1:0];
			VEC_CH_AR: ar <= p[$bits(ar)-1:0];
			default:   r <= p[$bits(r)-1:0];
		endcase
		if (v && rd && chan == VEC_CH_AW) begin
			aw_open++;
		end
		// Bit 0 of a W payload is WLAST
		if (v && rd && chan == VEC_CH_W && p[0]) begin
			w_open++;
		end
		// A response closes one of each and never takes a count below zero
		if (v && rd && chan == VEC_CH_B) begin
			aw_open = (aw_open > 0) ? aw_open - 1 : 0;
			w_open = (w_open > 0) ? w_open - 1 : 0;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge aclk);
			vld <= '0;
			rdy <= '0;
		end
	endtask

	// Accepted W beats, WLAST on the final one only
	task automatic send_w_burst(input int beats);
		logic [72:0] q;
		for (int i = 0; i < beats; i++) begin
			q = rand_payload();
			q[0] = (i == beats - 1);
			beat(VEC_CH_W, 1'b1, 1'b1, q);
		end
	endtask

	// Pairs every open AW with a complete burst and answers all of them,
	// so each scenario starts with no write outstanding
	task automatic drain_writes();
		while (aw_open < w_open)
			beat(VEC_CH_AW, 1'b1, 1'b1, rand_payload());
		while (w_open < aw_open)
			send_w_burst(1);
		while (aw_open > 0)
			beat(VEC_CH_B, 1'b1, 1'b1, rand_payload());
	endtask

	function automatic logic log_empty();
		return viol_status == '0 && first_viol == '0 && viol_count == '0;
	endfunction

	task automatic clear_log(input string test);
		int t;
		@(posedge aclk);
		vld <= '0;
		rdy <= '0;
		clr <= 1'b1;
		@(posedge aclk);
		clr <= 1'b0;
		t = 0;
		while (t < 20 && !log_empty()) begin
			@(negedge aclk);
			t++;
		end
		if (!log_empty()) begin
			errors++;
			$display("Timeout in %0s: the log did not clear after clr", test);
		end
	endtask

	task automatic wait_pulses(input string test, input int base, input int target);
		int t;
		t = 0;
		while (t < 20 && pulses - base < target) begin
			@(negedge aclk);
			t++;
		end
		if (pulses - base < target) begin
			errors++;
			$display("Timeout in %0s: only %0d of %0d violation pulses arrived",
				test, pulses - base, target);
		end
	endtask

	task automatic play(input vec_chan_e chan, input vec_kind_e kind, input int stall);
		logic [72:0] p;
		p = rand_payload();
		// A B beat needs an accepted AW and a complete W burst ahead of it
		if (chan == VEC_CH_B && kind inside {VEC_LEGAL_STALL, VEC_PAYLOAD_CHANGE,
				VEC_VALID_DROP}) begin
			beat(VEC_CH_AW, 1'b1, 1'b1, rand_payload());
			send_w_burst(1);
		end
		case (kind)
			VEC_PAYLOAD_CHANGE: begin
				beat(chan, 1'b1, 1'b0, p);
				// Bit 1 exists in every payload and is never WLAST
				p = p ^ 73'd2;
				repeat (stall - 1) beat(chan, 1'b1, 1'b0, p);
			end
			VEC_VALID_DROP: begin
				repeat (stall) beat(chan, 1'b1, 1'b0, p);
				beat(chan, 1'b0, 1'b0, p);
			end
			VEC_B_NO_WLAST: beat(VEC_CH_AW, 1'b1, 1'b1, rand_payload());
			VEC_LEGAL_WRITE: begin
				beat(VEC_CH_AW, 1'b1, 1'b1, rand_payload());
				send_w_burst(2);
			end
			VEC_TWO_WRITES: begin
				beat(VEC_CH_AW, 1'b1, 1'b1, rand_payload());
				beat(VEC_CH_AW, 1'b1, 1'b1, rand_payload());
				send_w_burst(3);
				send_w_burst(1);
				repeat (stall) beat(VEC_CH_B, 1'b1, 1'b0, p);
				beat(VEC_CH_B, 1'b1, 1'b1, p);
			end
			default: ;
		endcase
		// Every kind ends in an accepted beat, stalled first unless the stall was used above
		if (!(kind inside {VEC_PAYLOAD_CHANGE, VEC_VALID_DROP}))
			repeat (stall) beat(chan, 1'b1, 1'b0, p);
		beat(chan, 1'b1, 1'b1, p);
	endtask

	initial begin
		vec_t row;
		string test;
		int base;
		axi4_mon_pkg::viol_t exp_first;
		axi4_mon_pkg::viol_t exp_both;
		aclk = 1'b0;
		arst_n = 1'b0;
		clr = 1'b0;
		vld = '0;
		rdy = '0;
		aw = '0;
		w = '0;
		b = '0;
		ar = '0;
		r = '0;
		repeat (5) @(posedge aclk);
		arst_n <= 1'b1;
		@(negedge aclk);
		compare("reset", "viol_pulse", 0, viol_pulse);
		compare("reset", "viol_status", 0, viol_status);
		compare("reset", "first_viol", 0, first_viol);
		compare("reset", "viol_count", 0, viol_count);
		for (int i = 0; i < NUM_VECS; i++) begin
			row = VECS[i];
			test = string'(row.name);
			drain_writes();
			clear_log(test);
			base = pulses;
			play(row.chan, row.kind, int'(row.stall));
			idle(4);
			wait_pulses(test, base, int'(row.exp_incr));
			@(negedge aclk);
			// All flags of a scenario come in one cycle, so that cycle is also the first record
			compare(test, "viol_status", row.exp_status, viol_status);
			compare(test, "first_viol", row.exp_status, first_viol);
			compare(test, "viol_count", row.exp_incr, viol_count);
			compare(test, "pulses", row.exp_incr, pulses - base);
		end
		// An AR violation followed a few cycles later by an R violation
		drain_writes();
		clear_log("two_chan");
		base = pulses;
		play(VEC_CH_AR, VEC_PAYLOAD_CHANGE, 2);
		play(VEC_CH_R, VEC_VALID_DROP, 1);
		idle(4);
		wait_pulses("two_chan", base, 2);
		@(negedge aclk);
		exp_first = '0;
		exp_first.ar_unstable = 1'b1;
		exp_both = exp_first;
		exp_both.r_unstable = 1'b1;
		compare("two_chan", "first_viol", exp_first, first_viol);
		compare("two_chan", "viol_status", exp_both, viol_status);
		compare("two_chan", "viol_count", 2, viol_count);
		clear_log("two_chan_clr");
		@(negedge aclk);
		compare("two_chan_clr", "first_viol", 0, first_viol);
		compare("two_chan_clr", "viol_status", 0, viol_status);
		compare("two_chan_clr", "viol_count", 0, viol_count);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: files.f
+incdir+include
hw/axi4_mon_pkg.sv
hw/axi4_chan_stable.sv
hw/axi4_wresp_order.sv
hw/axi4_viol_log.sv
hw/axi4_mon_top.sv
verif/axi4_mon_tb.sv
